//--- hw/lsu_pkg.sv
package lsu_pkg;

  // Byte address and data word of the RV32 core
  typedef logic [31:0] addr_t;
  typedef logic [31:0] word_t;

  // Sequencing of one memory access
  // ISSUE is the cycle between capture and raising the bus valids
  typedef enum logic [2:0] {
    IDLE,
    ISSUE,
    READ_WAIT,
    WRITE_WAIT,
    WRITE_RESP
  } lsu_state_t;

endpackage

//--- hw/axi_pkg.sv
package axi_pkg;

  typedef logic [2:0] axi_size_t;
  typedef logic [3:0] strb_t;
  typedef logic [1:0] axi_resp_t;
  typedef logic [3:0] lat_t;

  // AXI size codes, log2 of the transfer size in bytes
  localparam axi_size_t SIZE_BYTE = 3'd0;
  localparam axi_size_t SIZE_HALF = 3'd1;
  localparam axi_size_t SIZE_WORD = 3'd2;

  localparam axi_resp_t RESP_OKAY = 2'b00;

  // On-chip memory, 4 KiB as 32-bit words
  localparam int MEM_WORDS = 1024;

  // Cycles from the request handshake to the response valid
  localparam lat_t MEM_LATENCY = 4'd2;

endpackage

//--- hw/axi_lite_if.sv
`timescale 1ns/10ps

interface axi_lite_if import lsu_pkg::*, axi_pkg::*; ();

  addr_t     araddr;
  axi_size_t arsize;
  logic      arvalid;
  logic      arready;

  word_t     rdata;
  axi_resp_t rresp;
  logic      rvalid;
  logic      rready;

  addr_t     awaddr;
  axi_size_t awsize;
  logic      awvalid;
  logic      awready;

  word_t     wdata;
  strb_t     wstrb;
  logic      wvalid;
  logic      wready;

  axi_resp_t bresp;
  logic      bvalid;
  logic      bready;

  modport master (
    output araddr, arsize, arvalid, rready,
    output awaddr, awsize, awvalid, wdata, wstrb, wvalid, bready,
    input  arready, rdata, rresp, rvalid, awready, wready, bresp, bvalid
  );

  modport slave (
    input  araddr, arsize, arvalid, rready,
    input  awaddr, awsize, awvalid, wdata, wstrb, wvalid, bready,
    output arready, rdata, rresp, rvalid, awready, wready, bresp, bvalid
  );

endinterface

//--- hw/lsu_fsm.sv
`timescale 1ns/10ps

module lsu_fsm import lsu_pkg::*; (
  input  logic       clock,
  input  logic       reset,
  input  logic       start_read,
  input  logic       start_write,
  input  logic       arready,
  input  logic       rvalid,
  input  logic       awready,
  input  logic       wready,
  input  logic       bvalid,
  output logic       arvalid,
  output logic       rready,
  output logic       awvalid,
  output logic       wvalid,
  output logic       bready,
  output logic       done,
  output lsu_state_t state
);

  logic op_write;
  logic aw_ok;
  logic w_ok;

  // A write channel counts as accepted once its valid has dropped,
  // so AW and W may complete in either order
  assign aw_ok = ~awvalid | awready;
  assign w_ok  = ~wvalid | wready;

  assign done = (rready & rvalid) | (bready & bvalid);

  always_ff @(posedge clock) begin
    if (reset) begin
      state    <= IDLE;
      op_write <= 1'b0;
      arvalid  <= 1'b0;
      rready   <= 1'b0;
      awvalid  <= 1'b0;
      wvalid   <= 1'b0;
      bready   <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (start_read | start_write) begin
            op_write <= ~start_read;
            state    <= ISSUE;
          end
        end
        ISSUE: begin
          if (op_write) begin
            // The memory side expects both write valids in the same cycle
            awvalid <= 1'b1;
            wvalid  <= 1'b1;
            state   <= WRITE_WAIT;
          end else begin
            arvalid <= 1'b1;
            state   <= READ_WAIT;
          end
        end
        READ_WAIT: begin
          if (arvalid & arready) begin
            arvalid <= 1'b0;
            rready  <= 1'b1;
          end
          if (rready & rvalid) begin
            rready <= 1'b0;
            state  <= IDLE;
          end
        end
        WRITE_WAIT: begin
          if (awvalid & awready) begin
            awvalid <= 1'b0;
          end
          if (wvalid & wready) begin
            wvalid <= 1'b0;
          end
          if (aw_ok & w_ok) begin
            bready <= 1'b1;
            state  <= WRITE_RESP;
          end
        end
        WRITE_RESP: begin
          if (bvalid) begin
            bready <= 1'b0;
            state  <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

endmodule

//--- hw/store_align.sv
`timescale 1ns/10ps

module store_align import lsu_pkg::*, axi_pkg::*; (
  input  logic       size_byte,
  input  logic       size_half,
  input  logic [1:0] offset,
  input  word_t      wsrc,
  output word_t      wdata,
  output strb_t      wstrb,
  output axi_size_t  size
);

  strb_t strb_base;

  assign size = size_byte ? SIZE_BYTE : (size_half ? SIZE_HALF : SIZE_WORD);

  assign strb_base = size_byte ? 4'b0001 : (size_half ? 4'b0011 : 4'b1111);

  // Sub-word data moves up to the byte lane picked by the address
  assign wdata = (size_byte | size_half) ? (wsrc << {offset, 3'b000}) : wsrc;
  assign wstrb = strb_base << offset;

endmodule

//--- hw/load_extend.sv
`timescale 1ns/10ps

module load_extend import lsu_pkg::*; (
  input  logic       size_byte,
  input  logic       size_half,
  input  logic       sext,
  input  logic [1:0] offset,
  input  word_t      rdata,
  output word_t      result
);

  word_t lane;
  logic  fill;

  // Bring the addressed byte or half down to bit 0
  assign lane = (size_byte | size_half) ? (rdata >> {offset, 3'b000}) : rdata;

  assign fill = sext & (size_byte ? lane[7] : lane[15]);

  always_comb begin
    if (size_byte) begin
      result = {{24{fill}}, lane[7:0]};
    end else if (size_half) begin
      result = {{16{fill}}, lane[15:0]};
    end else begin
      result = lane;
    end
  end

endmodule

//--- hw/lsu_unit.sv
`timescale 1ns/10ps

module lsu_unit import lsu_pkg::*; (
  input  logic             clock,
  input  logic             reset,
  input  logic             ren,
  input  logic             wen,
  input  logic             size_byte,
  input  logic             size_half,
  input  logic             sext,
  input  logic             execute_valid,
  input  logic             clear_pipeline,
  input  addr_t            addr,
  input  word_t            wsrc,
  input  word_t            exu_r_wdata,
  input  addr_t            exu_pc,
  output addr_t            lsu_pc,
  output word_t            r_wdata,
  output logic             block,
  output logic             ls_valid,
  axi_lite_if.master       bus
);

  addr_t      addr_q;
  word_t      wsrc_q;
  logic       size_byte_q;
  logic       size_half_q;
  logic       sext_q;
  logic       ren_q;
  logic       done;
  word_t      load_result;
  lsu_state_t state;

  // Request fields follow the execute stage while no access is running
  always_ff @(posedge clock) begin
    if (~block) begin
      addr_q      <= addr;
      wsrc_q      <= wsrc;
      size_byte_q <= size_byte;
      size_half_q <= size_half;
      sext_q      <= sext;
      lsu_pc      <= exu_pc;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      block    <= 1'b0;
      ls_valid <= 1'b0;
      ren_q    <= 1'b0;
    end else if (~block) begin
      ren_q <= ren;
      if (ren | wen) begin
        block    <= 1'b1;
        ls_valid <= 1'b0;
      end else begin
        ls_valid <= execute_valid & ~clear_pipeline;
      end
    end else if (done) begin
      block    <= 1'b0;
      ls_valid <= 1'b1;
    end
  end

  // Stores keep the pass-through value, only loads overwrite it
  always_ff @(posedge clock) begin
    if (~block) begin
      r_wdata <= exu_r_wdata;
    end else if (done & ren_q) begin
      r_wdata <= load_result;
    end
  end

  assign bus.araddr = addr_q;
  assign bus.awaddr = addr_q;
  assign bus.awsize = bus.arsize;

  lsu_fsm u_fsm (
    .clock       (clock),
    .reset       (reset),
    .start_read  (ren & ~block),
    .start_write (wen & ~block),
    .arready     (bus.arready),
    .rvalid      (bus.rvalid),
    .awready     (bus.awready),
    .wready      (bus.wready),
    .bvalid      (bus.bvalid),
    .arvalid     (bus.arvalid),
    .rready      (bus.rready),
    .awvalid     (bus.awvalid),
    .wvalid      (bus.wvalid),
    .bready      (bus.bready),
    .done        (done),
    .state       (state)
  );

  store_align u_store (
    .size_byte (size_byte_q),
    .size_half (size_half_q),
    .offset    (addr_q[1:0]),
    .wsrc      (wsrc_q),
    .wdata     (bus.wdata),
    .wstrb     (bus.wstrb),
    .size      (bus.arsize)
  );

  load_extend u_load (
    .size_byte (size_byte_q),
    .size_half (size_half_q),
    .sext      (sext_q),
    .offset    (addr_q[1:0]),
    .rdata     (bus.rdata),
    .result    (load_result)
  );

endmodule

//--- hw/mem_delay_timer.sv
`timescale 1ns/10ps

module mem_delay_timer import axi_pkg::*; (
  input  logic clock,
  input  logic reset,
  input  logic load,
  output logic done
);

  lat_t count;

  // A nonzero count means a delay is running
  always_ff @(posedge clock) begin
    if (reset) begin
      count <= lat_t'(0);
      done  <= 1'b0;
    end else if (load) begin
      count <= MEM_LATENCY;
      done  <= 1'b0;
    end else if (count != lat_t'(0)) begin
      count <= count - lat_t'(1);
      if (count == lat_t'(1)) begin
        done <= 1'b1;
      end
    end
  end

endmodule

//--- hw/axi_sram.sv
`timescale 1ns/10ps

module axi_sram import lsu_pkg::*, axi_pkg::*; (
  input  logic      clock,
  input  logic      reset,
  axi_lite_if.slave bus
);

  word_t      mem [MEM_WORDS];
  word_t      rdata_q;
  addr_t      aw_addr_q;
  word_t      w_data_q;
  strb_t      w_strb_q;
  logic       aw_got;
  logic       w_got;
  logic       pending;
  logic       resp_write;
  logic       timer_done;
  logic       ar_hs;
  logic       aw_hs;
  logic       w_hs;
  logic       write_go;
  logic [9:0] wr_idx;
  word_t      wr_data;
  strb_t      wr_strb;

  assign ar_hs    = bus.arvalid & bus.arready;
  assign aw_hs    = bus.awvalid & bus.awready;
  assign w_hs     = bus.wvalid & bus.wready;
  assign write_go = (aw_hs | aw_got) & (w_hs | w_got);

  // Whichever write channel arrives last is taken straight from the bus
  assign wr_idx  = aw_hs ? bus.awaddr[11:2] : aw_addr_q[11:2];
  assign wr_data = w_hs ? bus.wdata : w_data_q;
  assign wr_strb = w_hs ? bus.wstrb : w_strb_q;

  assign bus.arready = ~pending;
  assign bus.awready = ~pending & ~aw_got;
  assign bus.wready  = ~pending & ~w_got;
  assign bus.rvalid  = pending & ~resp_write & timer_done;
  assign bus.bvalid  = pending & resp_write & timer_done;
  assign bus.rdata   = rdata_q;
  assign bus.rresp   = RESP_OKAY;
  assign bus.bresp   = RESP_OKAY;

  always_ff @(posedge clock) begin
    if (reset) begin
      aw_got     <= 1'b0;
      w_got      <= 1'b0;
      pending    <= 1'b0;
      resp_write <= 1'b0;
    end else if (ar_hs) begin
      pending    <= 1'b1;
      resp_write <= 1'b0;
    end else if (write_go) begin
      pending    <= 1'b1;
      resp_write <= 1'b1;
      aw_got     <= 1'b0;
      w_got      <= 1'b0;
    end else begin
      if (aw_hs) aw_got <= 1'b1;
      if (w_hs) w_got <= 1'b1;
      if ((bus.rvalid & bus.rready) | (bus.bvalid & bus.bready)) begin
        pending <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (aw_hs) aw_addr_q <= bus.awaddr;
    if (w_hs) begin
      w_data_q <= bus.wdata;
      w_strb_q <= bus.wstrb;
    end
    if (ar_hs) rdata_q <= mem[bus.araddr[11:2]];
    if (write_go & ~ar_hs) begin
      for (int i = 0; i < 4; i++) begin
        if (wr_strb[i]) mem[wr_idx][8*i +: 8] <= wr_data[8*i +: 8];
      end
    end
  end

  mem_delay_timer u_timer (
    .clock (clock),
    .reset (reset),
    .load  (ar_hs | write_go),
    .done  (timer_done)
  );

endmodule

//--- hw/lsu_subsystem.sv
`timescale 1ns/10ps

module lsu_subsystem import lsu_pkg::*; (
  input  logic  clock,
  input  logic  reset,
  input  logic  ren,
  input  logic  wen,
  input  logic  size_byte,
  input  logic  size_half,
  input  logic  sext,
  input  addr_t addr,
  input  word_t wsrc,
  input  addr_t exu_pc,
  input  word_t exu_r_wdata,
  input  logic  execute_valid,
  input  logic  clear_pipeline,
  output addr_t lsu_pc,
  output word_t r_wdata,
  output logic  block,
  output logic  ls_valid
);

  axi_lite_if u_bus ();

  lsu_unit u_unit (
    .clock          (clock),
    .reset          (reset),
    .ren            (ren),
    .wen            (wen),
    .size_byte      (size_byte),
    .size_half      (size_half),
    .sext           (sext),
    .execute_valid  (execute_valid),
    .clear_pipeline (clear_pipeline),
    .addr           (addr),
    .wsrc           (wsrc),
    .exu_r_wdata    (exu_r_wdata),
    .exu_pc         (exu_pc),
    .lsu_pc         (lsu_pc),
    .r_wdata        (r_wdata),
    .block          (block),
    .ls_valid       (ls_valid),
    .bus            (u_bus.master)
  );

  axi_sram u_sram (
    .clock (clock),
    .reset (reset),
    .bus   (u_bus.slave)
  );

endmodule

//--- verif/lsu_subsystem_props.sv
`timescale 1ns/10ps

module lsu_subsystem_props import lsu_pkg::*; (
  input logic       clock,
  input logic       reset,
  input logic       arvalid,
  input logic       arready,
  input logic       rvalid,
  input logic       rready,
  input logic       awvalid,
  input logic       awready,
  input logic       wvalid,
  input logic       wready,
  input logic       bvalid,
  input logic       bready,
  input logic       block,
  input lsu_state_t state
);

  // A raised valid waits for its handshake
  assert property (@(posedge clock) disable iff (reset) arvalid && !arready |=> arvalid)
    else $error("arvalid dropped before arready");
  assert property (@(posedge clock) disable iff (reset) rvalid && !rready |=> rvalid)
    else $error("rvalid dropped before rready");
  assert property (@(posedge clock) disable iff (reset) awvalid && !awready |=> awvalid)
    else $error("awvalid dropped before awready");
  assert property (@(posedge clock) disable iff (reset) wvalid && !wready |=> wvalid)
    else $error("wvalid dropped before wready");
  assert property (@(posedge clock) disable iff (reset) bvalid && !bready |=> bvalid)
    else $error("bvalid dropped before bready");

  assert property (@(posedge clock) disable iff (reset) $rose(awvalid) == $rose(wvalid))
    else $error("awvalid and wvalid did not rise in the same cycle");

  assert property (@(posedge clock) disable iff (reset) state == IDLE |-> !block)
    else $error("block is high while the FSM is idle");

endmodule

bind lsu_subsystem lsu_subsystem_props u_props (
  .clock   (clock),
  .reset   (reset),
  .arvalid (u_bus.arvalid),
  .arready (u_bus.arready),
  .rvalid  (u_bus.rvalid),
  .rready  (u_bus.rready),
  .awvalid (u_bus.awvalid),
  .awready (u_bus.awready),
  .wvalid  (u_bus.wvalid),
  .wready  (u_bus.wready),
  .bvalid  (u_bus.bvalid),
  .bready  (u_bus.bready),
  .block   (block),
  .state   (u_unit.state)
);

//--- verif/lsu_subsystem_tb.sv
`timescale 1ns/10ps

module lsu_subsystem_tb import lsu_pkg::*, axi_pkg::*; ();

  localparam int WAIT_LIMIT = 50;

  logic  clock;
  logic  reset;
  logic  ren;
  logic  wen;
  logic  size_byte;
  logic  size_half;
  logic  sext;
  addr_t addr;
  word_t wsrc;
  addr_t exu_pc;
  word_t exu_r_wdata;
  logic  execute_valid;
  logic  clear_pipeline;
  addr_t lsu_pc;
  word_t r_wdata;
  logic  block;
  logic  ls_valid;

  logic [7:0]  mem_model [MEM_WORDS * 4];
  logic [15:0] lfsr_state;
  int          checks;
  int          errors;
  int          tests;
  logic        aborted;

  lsu_subsystem dut (
    .clock          (clock),
    .reset          (reset),
    .ren            (ren),
    .wen            (wen),
    .size_byte      (size_byte),
    .size_half      (size_half),
    .sext           (sext),
    .addr           (addr),
    .wsrc           (wsrc),
    .exu_pc         (exu_pc),
    .exu_r_wdata    (exu_r_wdata),
    .execute_valid  (execute_valid),
    .clear_pipeline (clear_pipeline),
    .lsu_pc         (lsu_pc),
    .r_wdata        (r_wdata),
    .block          (block),
    .ls_valid       (ls_valid)
  );

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic word_t take_bits(input int n);
    word_t v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  function automatic word_t fill_word(input addr_t a);
    return {a[15:0], a[31:16]} ^ ~a;
  endfunction

  function automatic axi_size_t pick_size(input word_t r);
    if (r[1:0] == 2'd0) return SIZE_BYTE;
    if (r[1:0] == 2'd1) return SIZE_HALF;
    return SIZE_WORD;
  endfunction

  function automatic word_t model_load(input addr_t a, input axi_size_t sz, input logic sx);
    int    base;
    word_t w;
    word_t lane;
    base = {20'd0, a[11:2], 2'b00};
    w = {mem_model[base + 3], mem_model[base + 2], mem_model[base + 1], mem_model[base]};
    lane = (sz == SIZE_WORD) ? w : w >> (8 * int'(a[1:0]));
    if (sz == SIZE_BYTE) return sx ? {{24{lane[7]}}, lane[7:0]} : {24'd0, lane[7:0]};
    if (sz == SIZE_HALF) return sx ? {{16{lane[15]}}, lane[15:0]} : {16'd0, lane[15:0]};
    return lane;
  endfunction

  task automatic model_store(input addr_t a, input axi_size_t sz, input word_t d);
    int         base;
    logic [7:0] lanes;
    word_t      data;
    base = {20'd0, a[11:2], 2'b00};
    lanes = (sz == SIZE_BYTE) ? 8'h01 : ((sz == SIZE_HALF) ? 8'h03 : 8'h0f);
    lanes = lanes << a[1:0];
    data = (sz == SIZE_WORD) ? d : d << (8 * int'(a[1:0]));
    for (int i = 0; i < 4; i++) begin
      if (lanes[i]) mem_model[base + i] = data[8*i +: 8];
    end
  endtask

  task automatic check_value(input string name, input word_t actual, input word_t expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("CHECK FAILED at %0t: %s actual 0x%08h expected 0x%08h",
               $time, name, actual, expected);
    end
  endtask

  task automatic drive_inputs(input logic rd, input logic wr, input axi_size_t sz,
                              input logic sx, input addr_t a, input word_t d,
                              input addr_t pc, input word_t val, input logic ev,
                              input logic clr);
    ren            = rd;
    wen            = wr;
    size_byte      = (sz == SIZE_BYTE);
    size_half      = (sz == SIZE_HALF);
    sext           = sx;
    addr           = a;
    wsrc           = d;
    exu_pc         = pc;
    exu_r_wdata    = val;
    execute_valid  = ev;
    clear_pipeline = clr;
  endtask

  task automatic finish_test(input string name, input int errors_before);
    tests++;
    $display("test %0d %s finished with %0d errors", tests, name, errors - errors_before);
  endtask

  // Every request task starts and ends 1 ns after a rising edge
  task automatic pass_through();
    addr_t pc;
    word_t val;
    logic  ev;
    logic  clr;
    if (aborted) return;
    pc  = take_bits(32);
    val = take_bits(32);
    ev  = take_bits(1) != 32'd0;
    clr = take_bits(1) != 32'd0;
    drive_inputs(1'b0, 1'b0, SIZE_WORD, 1'b0, '0, '0, pc, val, ev, clr);
    @(posedge clock);
    #1;
    check_value("ls_valid", word_t'(ls_valid), word_t'(ev & ~clr));
    check_value("r_wdata", r_wdata, val);
    check_value("lsu_pc", lsu_pc, pc);
    check_value("block", word_t'(block), 32'd0);
  endtask

  task automatic access(input logic is_write, input axi_size_t sz, input logic sx,
                        input addr_t a, input word_t d);
    addr_t pc;
    word_t val;
    word_t expected;
    int    cycles;
    if (aborted) return;
    pc  = take_bits(32);
    val = take_bits(32);
    drive_inputs(~is_write, is_write, sz, sx, a, d, pc, val, 1'b1, 1'b0);
    if (is_write) begin
      model_store(a, sz, d);
      expected = val;
    end else begin
      expected = model_load(a, sz, sx);
    end
    @(posedge clock);
    #1;
    drive_inputs(1'b0, 1'b0, SIZE_WORD, 1'b0, '0, '0, '0, '0, 1'b0, 1'b0);
    cycles = 0;
    while (ls_valid !== 1'b1 && cycles < WAIT_LIMIT) begin
      check_value("block", word_t'(block), 32'd1);
      @(posedge clock);
      #1;
      cycles++;
    end
    if (ls_valid !== 1'b1) begin
      $display("Timeout at %0t: ls_valid did not rise within %0d cycles of the request",
               $time, WAIT_LIMIT);
      aborted = 1'b1;
    end else begin
      check_value("block", word_t'(block), 32'd0);
      check_value("lsu_pc", lsu_pc, pc);
      check_value("r_wdata", r_wdata, expected);
    end
  endtask

  initial begin
    int        errs;
    addr_t     a;
    word_t     d;
    word_t     r;
    axi_size_t sz;
    lfsr_state = 16'd76;
    checks  = 0;
    errors  = 0;
    tests   = 0;
    aborted = 1'b0;
    reset   = 1'b1;
    drive_inputs(1'b0, 1'b0, SIZE_WORD, 1'b0, '0, '0, '0, '0, 1'b0, 1'b0);
    repeat (3) @(posedge clock);
    #1;
    reset = 1'b0;

    errs = errors;
    check_value("block", word_t'(block), 32'd0);
    check_value("ls_valid", word_t'(ls_valid), 32'd0);
    finish_test("reset", errs);

    // Give every memory word a known value before any load
    errs = errors;
    for (int i = 0; i < MEM_WORDS; i++) begin
      a = addr_t'(i * 4);
      access(1'b1, SIZE_WORD, 1'b0, a, fill_word(a));
    end
    finish_test("memory fill", errs);

    errs = errors;
    for (int i = 0; i < 20; i++) pass_through();
    finish_test("pass-through", errs);

    errs = errors;
    for (int i = 0; i < 20; i++) begin
      a = take_bits(10) << 2;
      d = take_bits(32);
      access(1'b1, SIZE_WORD, 1'b0, a, d);
      access(1'b0, SIZE_WORD, 1'b0, a, '0);
      access(1'b0, SIZE_WORD, 1'b0, take_bits(10) << 2, '0);
    end
    finish_test("word round trip", errs);

    errs = errors;
    for (int i = 0; i < 30; i++) begin
      a  = take_bits(12);
      sz = take_bits(1) ? SIZE_HALF : SIZE_BYTE;
      access(1'b1, sz, 1'b0, a, take_bits(32));
      access(1'b0, SIZE_WORD, 1'b0, {a[31:2], 2'b00}, '0);
    end
    finish_test("sub-word stores", errs);

    errs = errors;
    for (int off = 0; off < 4; off++) begin
      for (int k = 0; k < 4; k++) begin
        a = (take_bits(10) << 2) | addr_t'(off);
        access(1'b0, k[1] ? SIZE_HALF : SIZE_BYTE, k[0], a, '0);
      end
    end
    finish_test("sub-word loads", errs);

    errs = errors;
    for (int i = 0; i < 200; i++) begin
      r  = take_bits(2);
      sz = pick_size(take_bits(2));
      a  = take_bits(12);
      if (sz == SIZE_WORD) a = {a[31:2], 2'b00};
      if (r == 0) pass_through();
      else if (r == 2) access(1'b1, sz, 1'b0, a, take_bits(32));
      else access(1'b0, sz, take_bits(1) != 32'd0, a, '0);
    end
    finish_test("mixed random sequence", errs);

    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0 && !aborted) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

//--- sources.f
hw/lsu_pkg.sv
hw/axi_pkg.sv
hw/axi_lite_if.sv
hw/lsu_fsm.sv
hw/store_align.sv
hw/load_extend.sv
hw/lsu_unit.sv
hw/mem_delay_timer.sv
hw/axi_sram.sv
hw/lsu_subsystem.sv
verif/lsu_subsystem_props.sv
verif/lsu_subsystem_tb.sv

//--- run.sh
#!/bin/sh
# Build with Verilator, run, and decide the result from the simulation log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f sources.f \
  --top-module lsu_subsystem_tb -Mdir obj_dir -o lsu_sim \
  && ./obj_dir/lsu_sim | tee sim.log
grep -q '^TESTBENCH PASSED$' sim.log && echo "run.sh: simulation ok" \
  || { echo "run.sh: simulation did not pass"; exit 1; }
